//--- compile.f
src/com_pkg.sv
src/divider.sv
src/pixel_mask.sv
src/center_of_mass.sv
src/blob_tracker.sv
test/blob_tracker_tb.sv

//--- src/blob_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module blob_tracker import com_pkg::*; (
    input wire clk_in,
    input wire rst_in,
    input wire [PIXEL_WIDTH-1:0] pixel_in,
    input wire [X_WIDTH-1:0] x_in,
    input wire [Y_WIDTH-1:0] y_in,
    input wire valid_in,
    input wire frame_done_in,
    input wire [RED_WIDTH-1:0] red_min_in,
    input wire [GREEN_WIDTH-1:0] green_max_in,
    input wire [BLUE_WIDTH-1:0] blue_max_in,
    output logic [X_WIDTH-1:0] x_out,
    output logic [Y_WIDTH-1:0] y_out,
    output logic found_out,
    output logic valid_out
);

    logic [X_WIDTH-1:0] mask_x;
    logic [Y_WIDTH-1:0] mask_y;
    logic mask_hit;
    logic mask_tabulate;  // frame done, one cycle late

    pixel_mask u_pixel_mask (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .pixel_in(pixel_in),
        .x_in(x_in),
        .y_in(y_in),
        .valid_in(valid_in),
        .frame_done_in(frame_done_in),
        .red_min_in(red_min_in),
        .green_max_in(green_max_in),
        .blue_max_in(blue_max_in),
        .x_out(mask_x),
        .y_out(mask_y),
        .hit_out(mask_hit),
        .tabulate_out(mask_tabulate)
    );

    center_of_mass u_center_of_mass (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .x_in(mask_x),
        .y_in(mask_y),
        .valid_in(mask_hit),
        .tabulate_in(mask_tabulate),
        .x_out(x_out),
        .y_out(y_out),
        .found_out(found_out),
        .valid_out(valid_out)
    );

endmodule

`default_nettype wire

//--- src/center_of_mass.sv
`timescale 1ns/10ps
`default_nettype none

module center_of_mass import com_pkg::*; (
    input wire clk_in,
    input wire rst_in,
    input wire [X_WIDTH-1:0] x_in,
    input wire [Y_WIDTH-1:0] y_in,
    input wire valid_in,
    input wire tabulate_in,
    output logic [X_WIDTH-1:0] x_out,
    output logic [Y_WIDTH-1:0] y_out,
    output logic found_out,
    output logic valid_out
);

    enum logic [1:0] {
        ACQUIRE,
        CALC_X,
        CALC_Y
    } state;

    logic [SUM_WIDTH-1:0] x_sum;
    logic [SUM_WIDTH-1:0] y_sum;
    logic [SUM_WIDTH-1:0] count;
    logic [SUM_WIDTH-1:0] x_operand;  // frame being divided while the next one accumulates
    logic [SUM_WIDTH-1:0] y_operand;
    logic [SUM_WIDTH-1:0] count_operand;
    logic frame_start;
    logic empty_frame;
    logic div_start;
    logic [SUM_WIDTH-1:0] div_dividend;
    logic [SUM_WIDTH-1:0] div_quotient;
    logic div_done;

    assign frame_start = tabulate_in && (state == ACQUIRE);  // tabulate while busy is dropped
    assign empty_frame = (count == '0);
    assign div_dividend = (state == CALC_Y) ? y_operand : x_operand;

    divider u_divider (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .dividend_in(div_dividend),
        .divisor_in(count_operand),
        .data_valid_in(div_start),
        .quotient_out(div_quotient),
        .data_valid_out(div_done)
    );

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            x_sum <= '0;
            y_sum <= '0;
            count <= '0;
        end else if (frame_start) begin
            // a hit arriving with tabulate already belongs to the next frame
            x_sum <= valid_in ? SUM_WIDTH'(x_in) : '0;
            y_sum <= valid_in ? SUM_WIDTH'(y_in) : '0;
            count <= SUM_WIDTH'(valid_in);
        end else if (valid_in) begin
            x_sum <= x_sum + SUM_WIDTH'(x_in);
            y_sum <= y_sum + SUM_WIDTH'(y_in);
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (frame_start) begin
            x_operand <= x_sum;
            y_operand <= y_sum;
            count_operand <= count;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= ACQUIRE;
            div_start <= 1'b0;
            valid_out <= 1'b0;
            found_out <= 1'b0;
        end else begin
            div_start <= 1'b0;
            valid_out <= 1'b0;
            case (state)
                ACQUIRE: begin
                    if (tabulate_in && empty_frame) begin
                        valid_out <= 1'b1;  // nothing to divide, report straight away
                        found_out <= 1'b0;
                    end else if (tabulate_in) begin
                        div_start <= 1'b1;
                        state <= CALC_X;
                    end
                end
                CALC_X: begin
                    if (div_done) begin
                        div_start <= 1'b1;  // same divisor, y sum goes in next
                        state <= CALC_Y;
                    end
                end
                CALC_Y: begin
                    if (div_done) begin
                        valid_out <= 1'b1;
                        found_out <= 1'b1;
                        state <= ACQUIRE;
                    end
                end
                default: state <= ACQUIRE;
            endcase
        end
    end

    // a mean never exceeds its largest input, so the upper quotient bits are zero
    always_ff @(posedge clk_in) begin
        if (frame_start && empty_frame) begin
            x_out <= '0;
            y_out <= '0;
        end else if (div_done && (state == CALC_X)) begin
            x_out <= div_quotient[X_WIDTH-1:0];
        end else if (div_done && (state == CALC_Y)) begin
            y_out <= div_quotient[Y_WIDTH-1:0];
        end
    end

    single_cycle_result: assert property (
        @(posedge clk_in) disable iff (rst_in)
        valid_out |=> !valid_out
    ) else $error("centroid valid held for more than one cycle");

    no_empty_division: assert property (
        @(posedge clk_in) disable iff (rst_in)
        div_start |-> (count_operand != '0)
    ) else $error("division started for a frame with no hits");

endmodule

`default_nettype wire

//--- src/com_pkg.sv
package com_pkg;

    // pixel coordinates as delivered by the camera front end
    localparam int X_WIDTH = 11;
    localparam int Y_WIDTH = 10;

    // accumulators, pixel count and divider operands all share this width
    localparam int SUM_WIDTH = 32;

    // one quotient bit per step, so the step counter only has to reach SUM_WIDTH - 1
    localparam int STEP_WIDTH = $clog2(SUM_WIDTH);

    // RGB565 layout, red in the top bits
    localparam int PIXEL_WIDTH = 16;

    localparam int RED_WIDTH = 5;
    localparam int GREEN_WIDTH = 6;
    localparam int BLUE_WIDTH = 5;

    localparam int RED_LSB = 11;   // bits 15:11
    localparam int GREEN_LSB = 5;  // bits 10:5
    localparam int BLUE_LSB = 0;   // bits 4:0

endpackage

//--- src/divider.sv
`timescale 1ns/10ps
`default_nettype none

module divider import com_pkg::*; (
    input wire clk_in,
    input wire rst_in,
    input wire [SUM_WIDTH-1:0] dividend_in,
    input wire [SUM_WIDTH-1:0] divisor_in,
    input wire data_valid_in,
    output logic [SUM_WIDTH-1:0] quotient_out,
    output logic data_valid_out
);

    logic [SUM_WIDTH-1:0] dividend_r;  // dividend bits leave at the top, quotient bits enter below
    logic [SUM_WIDTH-1:0] divisor_r;
    logic [SUM_WIDTH-1:0] remainder_r;
    logic [SUM_WIDTH:0] trial;         // partial remainder with the next dividend bit appended
    logic [SUM_WIDTH:0] difference;
    logic [SUM_WIDTH-1:0] next_remainder;
    logic [SUM_WIDTH-1:0] next_dividend;
    logic quotient_bit;
    logic busy;
    logic [STEP_WIDTH-1:0] step_count;
    logic last_step;

    // restoring step: subtract only when the divisor fits
    always_comb begin
        trial = {remainder_r, dividend_r[SUM_WIDTH-1]};
        difference = trial - {1'b0, divisor_r};
        quotient_bit = (trial >= {1'b0, divisor_r});
        next_remainder = quotient_bit ? difference[SUM_WIDTH-1:0] : trial[SUM_WIDTH-1:0];
        next_dividend = {dividend_r[SUM_WIDTH-2:0], quotient_bit};
    end

    assign last_step = busy && (step_count == STEP_WIDTH'(SUM_WIDTH - 1));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy <= 1'b0;
            step_count <= '0;
            data_valid_out <= 1'b0;
        end else begin
            data_valid_out <= 1'b0;
            if (data_valid_in) begin
                busy <= 1'b1;
                step_count <= '0;
            end else if (busy) begin
                step_count <= step_count + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                    data_valid_out <= 1'b1;  // result is ready on the cycle after the last step
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (data_valid_in) begin
            dividend_r <= dividend_in;
            divisor_r <= divisor_in;
            remainder_r <= '0;
        end else if (busy) begin
            dividend_r <= next_dividend;
            remainder_r <= next_remainder;
            if (last_step) begin
                quotient_out <= next_dividend;  // after the final shift the whole word is quotient
            end
        end
    end

    // the sequencer upstream must wait for the done pulse before starting again
    start_while_idle: assert property (
        @(posedge clk_in) disable iff (rst_in)
        data_valid_in |-> !busy
    ) else $error("divider started while a division was still running");

    // an empty frame has to be handled before it gets here
    nonzero_divisor: assert property (
        @(posedge clk_in) disable iff (rst_in)
        data_valid_in |-> (divisor_in != '0)
    ) else $error("divider started with a zero divisor");

endmodule

`default_nettype wire

//--- src/pixel_mask.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_mask import com_pkg::*; (
    input wire clk_in,
    input wire rst_in,
    input wire [PIXEL_WIDTH-1:0] pixel_in,
    input wire [X_WIDTH-1:0] x_in,
    input wire [Y_WIDTH-1:0] y_in,
    input wire valid_in,
    input wire frame_done_in,
    input wire [RED_WIDTH-1:0] red_min_in,
    input wire [GREEN_WIDTH-1:0] green_max_in,
    input wire [BLUE_WIDTH-1:0] blue_max_in,
    output logic [X_WIDTH-1:0] x_out,
    output logic [Y_WIDTH-1:0] y_out,
    output logic hit_out,
    output logic tabulate_out
);

    logic [RED_WIDTH-1:0] red;
    logic [GREEN_WIDTH-1:0] green;
    logic [BLUE_WIDTH-1:0] blue;
    logic in_bounds;

    assign red = pixel_in[RED_LSB +: RED_WIDTH];
    assign green = pixel_in[GREEN_LSB +: GREEN_WIDTH];
    assign blue = pixel_in[BLUE_LSB +: BLUE_WIDTH];

    // strong red with little green and blue counts as part of the blob
    assign in_bounds = (red >= red_min_in)
                    && (green <= green_max_in)
                    && (blue <= blue_max_in);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            hit_out <= 1'b0;
            tabulate_out <= 1'b0;
        end else begin
            hit_out <= valid_in && in_bounds;
            tabulate_out <= frame_done_in;  // keeps frame done aligned with the last hit
        end
    end

    // coordinates ride along with the hit strobe
    always_ff @(posedge clk_in) begin
        x_out <= x_in;
        y_out <= y_in;
    end

endmodule

`default_nettype wire

//--- test/blob_tracker_tb.sv
`timescale 1ns/10ps

module blob_tracker_tb import com_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 8;
    localparam int RESULT_TIMEOUT = 200;
    localparam int FULL_LATENCY = 70;   // frame done to centroid, two divisions
    localparam int EMPTY_LATENCY = 2;   // mask stage plus the direct empty report
    localparam TRACE_FILE = "test/blob_tracker_trace.txt";

    logic clk_in;
    logic rst_in;
    logic [PIXEL_WIDTH-1:0] pixel_in;
    logic [X_WIDTH-1:0] x_in;
    logic [Y_WIDTH-1:0] y_in;
    logic valid_in;
    logic frame_done_in;
    logic [RED_WIDTH-1:0] red_min_in;
    logic [GREEN_WIDTH-1:0] green_max_in;
    logic [BLUE_WIDTH-1:0] blue_max_in;
    logic [X_WIDTH-1:0] x_out;
    logic [Y_WIDTH-1:0] y_out;
    logic found_out;
    logic valid_out;

    // frames that have been closed and still wait for their centroid
    string exp_name[$];
    logic [31:0] exp_found[$];
    logic [31:0] exp_x[$];
    logic [31:0] exp_y[$];
    int exp_start[$];

    int cycle_count = 0;
    int error_count = 0;
    int check_count = 0;
    int frame_count = 0;
    bit timed_out = 1'b0;
    bit valid_last = 1'b0;

    blob_tracker u_blob_tracker (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .pixel_in(pixel_in),
        .x_in(x_in),
        .y_in(y_in),
        .valid_in(valid_in),
        .frame_done_in(frame_done_in),
        .red_min_in(red_min_in),
        .green_max_in(green_max_in),
        .blue_max_in(blue_max_in),
        .x_out(x_out),
        .y_out(y_out),
        .found_out(found_out),
        .valid_out(valid_out)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        error_count++;
        $display("[ERROR] %0s: %0s expected %0d actual %0d", name, what, expected, actual);
    endtask

    task automatic wait_for_results();
        int cycles;
        cycles = 0;
        while (exp_name.size() != 0 && cycles < RESULT_TIMEOUT) begin
            @(posedge clk_in);
            cycles++;
        end
        if (exp_name.size() != 0) begin
            error_count++;
            timed_out = 1'b1;
            $display("no centroid arrived for frame %0s within %0d cycles",
                     exp_name[0], RESULT_TIMEOUT);
        end
    endtask

    task automatic apply_bounds(input logic [RED_WIDTH-1:0] red_min,
                                input logic [GREEN_WIDTH-1:0] green_max,
                                input logic [BLUE_WIDTH-1:0] blue_max);
        @(posedge clk_in);
        valid_in <= 1'b0;
        red_min_in <= red_min;
        green_max_in <= green_max;
        blue_max_in <= blue_max;
    endtask

    task automatic send_pixel(input logic [PIXEL_WIDTH-1:0] pixel, input logic [X_WIDTH-1:0] x,
                              input logic [Y_WIDTH-1:0] y, input int idle);
        @(posedge clk_in);
        pixel_in <= pixel;
        x_in <= x;
        y_in <= y;
        valid_in <= 1'b1;
        repeat (idle) begin
            @(posedge clk_in);
            valid_in <= 1'b0;
        end
    endtask

    task automatic end_frame(input string name, input int found, input int x, input int y,
                             input int hold);
        @(posedge clk_in);
        valid_in <= 1'b0;
        wait_for_results();  // a tabulate while the divider is busy would be dropped
        if (!timed_out) begin
            @(posedge clk_in);
            frame_done_in <= 1'b1;
            exp_name.push_back(name);
            exp_found.push_back(found);
            exp_x.push_back(x);
            exp_y.push_back(y);
            exp_start.push_back(cycle_count);
            frame_count++;
            @(posedge clk_in);
            frame_done_in <= 1'b0;
            if (hold != 0) begin
                wait_for_results();
            end
        end
    endtask

    // outputs are sampled half a cycle after the edge that updates them
    initial begin : result_checker
        int latency;
        int expected_latency;
        forever begin
            @(negedge clk_in);
            if (valid_out === 1'b1 && valid_last) begin
                error_count++;
                $display("valid_out stayed high for more than one cycle at cycle %0d", cycle_count);
            end else if (valid_out === 1'b1 && exp_name.size() == 0) begin
                error_count++;
                $display("valid_out pulsed at cycle %0d with no frame waiting", cycle_count);
            end else if (valid_out === 1'b1) begin
                latency = cycle_count - exp_start[0] - 1;
                expected_latency = (exp_found[0] != 0) ? FULL_LATENCY : EMPTY_LATENCY;
                check_count += 4;
                if (32'(found_out) !== exp_found[0]) begin
                    report_mismatch(exp_name[0], "found", exp_found[0], 32'(found_out));
                end
                if (32'(x_out) !== exp_x[0]) begin
                    report_mismatch(exp_name[0], "x", exp_x[0], 32'(x_out));
                end
                if (32'(y_out) !== exp_y[0]) begin
                    report_mismatch(exp_name[0], "y", exp_y[0], 32'(y_out));
                end
                if (latency != expected_latency) begin
                    report_mismatch(exp_name[0], "latency", expected_latency, latency);
                end
                void'(exp_name.pop_front());
                void'(exp_found.pop_front());
                void'(exp_x.pop_front());
                void'(exp_y.pop_front());
                void'(exp_start.pop_front());
            end
            valid_last = (valid_out === 1'b1);
        end
    end

    initial begin : trace_runner
        int fd;
        int n;
        int a1;
        int a2;
        int a3;
        int a4;
        string line;
        string cmd;
        string name;
        logic [PIXEL_WIDTH-1:0] pixel;
        rst_in = 1'b1;
        pixel_in = '0;
        x_in = '0;
        y_in = '0;
        valid_in = 1'b0;
        frame_done_in = 1'b0;
        red_min_in = '1;
        green_max_in = '0;
        blue_max_in = '0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst_in <= 1'b0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open the trace file %0s", TRACE_FILE);
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s", cmd);
                if (n != 1 || cmd == "#") begin
                    continue;  // blank line or column description
                end
                if (cmd == "b" && $sscanf(line, "%s %d %d %d", cmd, a1, a2, a3) == 4) begin
                    apply_bounds(a1[RED_WIDTH-1:0], a2[GREEN_WIDTH-1:0], a3[BLUE_WIDTH-1:0]);
                end else if (cmd == "p"
                             && $sscanf(line, "%s %h %d %d %d", cmd, pixel, a1, a2, a3) == 5) begin
                    send_pixel(pixel, a1[X_WIDTH-1:0], a2[Y_WIDTH-1:0], a3);
                end else if (cmd == "f"
                             && $sscanf(line, "%s %s %d %d %d %d", cmd, name, a1, a2, a3, a4)
                                == 6) begin
                    end_frame(name, a1, a2, a3, a4);
                end else begin
                    error_count++;
                    $display("the trace holds a line that cannot be read: %0s", line);
                end
            end
            $fclose(fd);
            if (!timed_out) begin
                wait_for_results();
            end
        end
        repeat (4) @(posedge clk_in);
        $display("frames: %0d, checks: %0d, errors: %0d", frame_count, check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- test/blob_tracker_trace.txt
# blob tracker trace, one command per line, numbers decimal except the colour
# b red_min green_max blue_max    colour bounds for the pixels that follow
# p rgb565_hex x y idle           one pixel, then idle cycles with valid low
# f name found x y hold           frame done and expected centroid, hold 1 waits for it
b 16 16 16
p F800 100 200 0
f single_pixel 1 100 200 1
p F800 10 20 1
p F800 11 21 0
p F800 13 26 3
f averaging 1 11 22 1
p F800 2047 1023 0
p F800 2046 1022 2
p F800 2045 1021 0
p F800 2047 1023 0
f edge_coords 1 2046 1022 1
p F800 100 50 0
p 07E0 900 900 0
p 001F 800 10 1
p A145 300 150 0
p 7800 5 5 0
f filter_loose 1 200 100 1
b 24 4 4
p F800 100 50 0
p A145 300 150 0
p C000 401 77 2
p 7800 5 5 0
f filter_tight 1 250 63 1
p A145 10 10 0
p 07E0 20 20 0
f empty_frame 0 0 0 1
f no_pixels 0 0 0 1
b 16 16 16
p F800 500 300 0
p F800 503 301 1
p F800 510 310 0
f overlap_first 1 504 303 0
p F800 7 9 4
p A145 8 12 4
p F800 20 1 4
f overlap_second 1 11 7 1
